// File: Makefile
SIM := obj_dir/Vpa_tb
SRCS := $(shell grep -v '^+' verilog.f)

$(SIM): verilog.f $(SRCS)
	verilator --binary --assert --top-module pa_tb -f verilog.f -o Vpa_tb

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: bench/pa_props.sv
`timescale 1ns/1ps

module pa_props (
	input logic clk,
	input logic arst_n,
	input logic w_dt,
	input logic ar_ad,
	input logic ic_ad,
	input logic wzi,
	input pa_pkg::word_t ddt_,
	input pa_pkg::word_t dad_
);

	// data bus idles high
	ddt_idle: assert property (@(posedge clk) disable iff (!arst_n)
		!w_dt |-> ddt_ == 16'hffff)
		else $error("ddt_ is driven while w_dt is low");

	// address bus idles high with no source enabled
	dad_idle: assert property (@(posedge clk) disable iff (!arst_n)
		(!ar_ad && !ic_ad) |-> dad_ == 16'hffff)
		else $error("dad_ is driven while ar_ad and ic_ad are low");

	wzi_reset: assert property (@(posedge clk) $rose(arst_n) |-> !wzi)
		else $error("wzi is set right after reset");

endmodule

bind pa pa_props u_props (
	.clk, .arst_n, .w_dt, .ar_ad, .ic_ad, .wzi, .ddt_, .dad_
);

// File: bench/pa_tb.sv
`timescale 1ns/1ps

module pa_tb;
	import pa_pkg::*;

	// control bits of a table row from the lsb up
	localparam logic [30:0] c_bwa = 31'd1 << 0, c_bwb = 31'd1 << 1, c_aa = 31'd1 << 2;
	localparam logic [30:0] c_ab = 31'd1 << 3, c_f0 = 31'd1 << 4, c_f1 = 31'd1 << 5;
	localparam logic [30:0] c_f2 = 31'd1 << 6, c_f3 = 31'd1 << 7, c_ary = 31'd1 << 8;
	localparam logic [30:0] c_p16 = 31'd1 << 9, c_s1 = 31'd1 << 10, c_s2 = 31'd1 << 11;
	localparam logic [30:0] c_as2 = 31'd1 << 12, c_wac = 31'd1 << 13, c_war = 31'd1 << 14;
	localparam logic [30:0] c_wic = 31'd1 << 15, c_wdt = 31'd1 << 16, c_arp1 = 31'd1 << 17;
	localparam logic [30:0] c_arm4 = 31'd1 << 18, c_icp1 = 31'd1 << 19, c_off = 31'd1 << 20;
	localparam logic [30:0] c_arad = 31'd1 << 21, c_icad = 31'd1 << 22, c_barnb = 31'd1 << 23;
	localparam logic [30:0] c_wx = 31'd1 << 24, c_eat0 = 31'd1 << 25, c_axy = 31'd1 << 26;
	localparam logic [30:0] c_am1 = 31'd1 << 27, c_apb = 31'd1 << 28, c_amb = 31'd1 << 29;
	localparam logic [30:0] c_ap1 = 31'd1 << 30, c_bw = c_bwa | c_bwb;
	// 74181 function codes {S3, S2, S1, S0}
	localparam logic [30:0] c_fadd = c_f3 | c_f0 | c_ary, c_fand = c_f3 | c_f1 | c_f0;
	localparam logic [30:0] c_fxor = c_f2 | c_f1, c_fpass = c_f3 | c_f2 | c_f1 | c_f0;
	// flag outputs from the msb down as s0 carry j$ exx at15 exy s_1 wzi zs arz zga
	localparam logic [10:0] x_s0 = 11'd1 << 10, x_carry = 11'd1 << 9, x_j = 11'd1 << 8;
	localparam logic [10:0] x_exx = 11'd1 << 7, x_at15 = 11'd1 << 6, x_exy = 11'd1 << 5;
	localparam logic [10:0] x_s_1 = 11'd1 << 4, x_wzi = 11'd1 << 3, x_zs = 11'd1 << 2;
	localparam logic [10:0] x_arz = 11'd1 << 1, x_zga = 11'd1 << 0;

	typedef struct {
		wsel_t ws;
		asel_t as;
		logic [30:0] ctl;
		word_t ir, rdt, ki, l, kl;
		word_t w, dad;
		// expected flag values and the flags that are checked
		logic [10:0] eb, em;
	} row_t;

	logic clk, arst_n, w_dt, mwa, mwb, mwc, bwa, bwb;
	logic saryt, sab, scb, saa, sca, sb, sd, p16, s0, carry, j$, exx;
	logic wx, eat0, axy, at15, exy, w_ac, strob1, strob2, as2;
	logic am1, apb, amb, ap1, s_1, wzi, zs, w_ar, arp1, arm4, w_ic, icp1, off, arz;
	logic baa, bab, bac, aa, ab, barnb, ar_ad, ic_ad, zga;
	word_t ir, bus_ki, rdt_, ddt_, w, l, kl, dad_;

	row_t tbl[$];
	logic [31:0] lfsr = 32'h6125_e1fc;
	int nerr = 0;
	int nchk = 0;
	int cur_row = 0;
	int cycles = 0;
	int limit = 0;

	pa #(.ar_step(4)) uut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) lfsr = lfsr ^ 32'h8020_0003;
		return b;
	endfunction

	function word_t rand_word();
		word_t v;
		v = '0;
		for (int i = 0; i < 16; i++) v = {v[1:15], lfsr_bit()};
		return v;
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		nchk++;
		if (act !== exp) begin
			nerr++;
			$display("FAILED %s row %0d: expected %h, got %h", name, cur_row, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		nchk++;
		if (act !== exp) begin
			nerr++;
			$display("FAILED %s row %0d: expected %h, got %h", name, cur_row, exp, act);
		end
	endtask

	task automatic put(input row_t r);
		tbl.push_back(r);
	endtask

	task automatic drive(input row_t r);
		{mwc, mwb, mwa} = r.ws;
		{bac, bab, baa} = r.as;
		{ap1, amb, apb, am1, axy, eat0, wx, barnb, ic_ad, ar_ad, off, icp1, arm4, arp1,
			w_dt, w_ic, w_ar, w_ac, as2, strob2, strob1, p16, saryt, sd, sb, sca, saa,
			ab, aa, bwb, bwa} = r.ctl;
		// both byte slices share one function code
		sab = r.ctl[4];
		scb = r.ctl[5];
		ir = r.ir;
		rdt_ = r.rdt;
		bus_ki = r.ki;
		l = r.l;
		kl = r.kl;
	endtask

	task automatic verify_row(input row_t r);
		string names[11] = '{"s0", "carry", "j$", "exx", "at15", "exy", "s_1", "wzi", "zs",
			"arz", "zga"};
		logic [10:0] act;
		act = {s0, carry, j$, exx, at15, exy, s_1, wzi, zs, arz, zga};
		check_word("w", r.w, w);
		check_word("ddt_", r.ctl[16] ? ~r.w : 16'hffff, ddt_);
		check_word("dad_", r.dad, dad_);
		for (int i = 0; i < 11; i++) begin
			if (r.em[10 - i]) check_bit(names[i], r.eb[10 - i], act[10 - i]);
		end
	endtask

	// AR <- ki, AC <- ~rdt_, one ALU operation into AT, then AT and AC read back on W
	task automatic add_alu_rows(input int k);
		row_t r;
		word_t x, y, rd, f;
		logic [16:0] sum;
		logic [8:0] lo;
		logic p, sel, s1x, zsx;
		x = rand_word();
		rd = rand_word();
		y = ~rd;
		p = k[0];
		sum = 17'(x) + 17'(y) + 17'(p);
		lo = 9'(x[8:15]) + 9'(y[8:15]) + 9'(p);
		f = (k == 4) ? (x & y) : (k == 5) ? (x ^ y) : sum[15:0];
		case (k)
			0: sel = ~x[0];
			1: sel = x[0] ^ y[0];
			2: sel = ~(x[0] ^ y[0]);
			default: sel = x[0];
		endcase
		s1x = sel ^ sum[16];
		zsx = ~s1x & (f == 16'h0000);
		put('{ws_ki, asl_zero, c_bw | c_s1 | c_war, 0, 0, x, 0, 0, x, 16'hffff, 0, 0});
		put('{ws_rdt, asl_zero, c_bw | c_s2 | c_as2 | c_wac, 0, rd, 0, 0, 0, y, 16'hffff, 0, 0});
		r = '{ws_zero, asl_ar, c_s1 | c_as2, 0, 0, 0, 0, 0, 0, 16'hffff, 0, x_s0};
		r.eb = {f[0], sum[16], lo[8], 3'b000, s1x, 1'b0, zsx, 2'b00};
		if (k < 4) begin
			r.ctl = r.ctl | c_fadd | (p ? c_p16 : 31'd0) | (c_am1 << k);
			r.em = x_s0 | x_carry | x_j | x_s_1 | x_zs;
		end else begin
			r.ctl = r.ctl | ((k == 4) ? c_fand : c_fxor);
		end
		put(r);
		put('{ws_at, asl_zero, c_bw, 0, 0, 0, 0, 0, f, 16'hffff, {7'd0, zsx, 3'd0},
			(k < 4) ? x_wzi : 11'd0});
		// accumulator on the W bus
		put('{ws_ac, asl_zero, c_bw, 0, 0, 0, 0, 0, y, 16'hffff, 0, 0});
	endtask

	task automatic build_table();
		// W sources and byte gating
		put('{ws_ki, asl_zero, c_bw | c_wdt, 16'h1234, 16'h00ff, 16'ha5c3, 16'h5678,
			16'h0f0f, 16'ha5c3, 16'hffff, 0, 0});
		put('{ws_ir, asl_zero, c_bwa | c_wdt, 16'h1234, 16'h00ff, 16'ha5c3, 16'h5678,
			16'h0f0f, 16'h1200, 16'hffff, 0, 0});
		put('{ws_kl, asl_zero, c_bwb, 16'h1234, 16'h00ff, 16'ha5c3, 16'h5678,
			16'h0f0f, 16'h000f, 16'hffff, 0, 0});
		put('{ws_rdt, asl_zero, c_bw | c_wdt, 16'h1234, 16'h00ff, 16'ha5c3, 16'h5678,
			16'h0f0f, 16'hff00, 16'hffff, 0, 0});
		put('{ws_ac, asl_zero, c_bw, 16'h1234, 0, 0, 0, 0, 0, 16'hffff, 0, x_wzi | x_at15});
		put('{ws_at, asl_zero, c_bw, 16'h1234, 0, 0, 0, 0, 0, 16'hffff, 0, 0});
		put('{ws_a, asl_l, c_bw | c_wdt, 16'h1234, 0, 0, 16'h5678, 0, 16'h5678, 16'hffff,
			0, x_exx});
		put('{ws_a, asl_l, c_bw | c_aa, 16'h1234, 0, 0, 16'h5678, 0, 16'h0078, 16'hffff, 0, 0});
		put('{ws_a, asl_l, c_bw | c_ab, 16'h1234, 0, 0, 16'h5678, 0, 16'hff78, 16'hffff, 0, 0});
		put('{ws_a, asl_irs, c_bw, 16'h1234, 0, 0, 0, 0, 16'h0034, 16'hffff, 0, 0});
		put('{ws_a, asl_ones, c_bw | c_aa | c_ab, 16'h1234, 0, 0, 0, 0, 16'hffff, 16'hffff,
			x_exx, x_exx});
		put('{ws_zero, asl_zero, c_bw | c_wdt, 0, 0, 0, 0, 0, 0, 16'hffff, 0, 0});
		for (int k = 0; k < 6; k++) add_alu_rows(k);
		// zero sum captured into WZI, then held
		put('{ws_zero, asl_zero, c_bw | c_s1 | c_wac | c_war, 0, 0, 0, 0, 0, 0, 16'hffff, 0, 0});
		put('{ws_zero, asl_ar, c_fadd | c_ap1 | c_s1 | c_as2, 0, 0, 0, 0, 0, 0, 16'hffff,
			x_zs, x_s0 | x_carry | x_j | x_s_1 | x_zs});
		put('{ws_zero, asl_zero, c_s1, 0, 0, 0, 0, 0, 0, 16'hffff, x_wzi, x_wzi});
		put('{ws_zero, asl_zero, 0, 0, 0, 0, 0, 0, 0, 16'hffff, x_wzi, x_wzi});
		// AR load, increment, step down
		put('{ws_ki, asl_zero, c_bw | c_s1 | c_war, 0, 0, 16'h1203, 0, 0, 16'h1203, 16'hffff,
			0, 0});
		put('{ws_zero, asl_zero, c_s1 | c_arp1 | c_arad, 0, 0, 0, 0, 0, 0, 16'hedfc, x_arz, x_arz});
		put('{ws_zero, asl_zero, c_arm4 | c_arad, 0, 0, 0, 0, 0, 0, 16'hedfb, x_arz, x_arz});
		put('{ws_zero, asl_zero, c_arm4 | c_arad, 0, 0, 0, 0, 0, 0, 16'hedff, 0, 0});
		put('{ws_ki, asl_zero, c_bw | c_s2 | c_as2 | c_war | c_arad, 0, 0, 16'h0007, 0, 0,
			16'h0007, 16'hee03, x_arz, x_arz});
		put('{ws_zero, asl_zero, c_arad, 0, 0, 0, 0, 0, 0, 16'hfff8, 0, x_arz});
		// IC load, increment, clear, key compare
		put('{ws_ki, asl_zero, c_bw | c_s1 | c_wic, 0, 0, 16'h8421, 0, 0, 16'h8421, 16'hffff,
			0, 0});
		put('{ws_zero, asl_zero, c_s1 | c_icp1 | c_icad, 0, 0, 0, 0, 16'h0421, 0, 16'h7bde,
			x_zga, x_zga});
		put('{ws_zero, asl_zero, c_icad, 0, 0, 0, 0, 16'h0421, 0, 16'h7bdd, 0, x_zga});
		put('{ws_zero, asl_zero, c_icad | c_barnb | c_off, 0, 0, 0, 0, 16'h8422, 0, 16'h7bdd,
			x_zga, x_zga});
		put('{ws_ki, asl_zero, c_bw | c_s1 | c_wic | c_off | c_icad, 0, 0, 16'h1111, 0, 0,
			16'h1111, 16'hffff, x_zga, x_zga});
		put('{ws_zero, asl_zero, c_icad, 0, 0, 0, 0, 0, 0, 16'hffff, 0, 0});
		// AT load from f and right shifts
		put('{ws_zero, asl_l, c_fpass | c_s1 | c_as2, 0, 0, 0, 16'hc003, 0, 0, 16'hffff,
			x_s0 | x_exx, x_s0 | x_exx});
		put('{ws_at, asl_zero, c_bw | c_s1 | c_wx | c_axy, 0, 0, 0, 0, 0, 16'hc003, 16'hffff,
			x_at15 | x_exy, x_at15 | x_exy});
		put('{ws_at, asl_zero, c_bw | c_s1 | c_wx | c_eat0 | c_axy, 0, 0, 0, 0, 0, 16'h6001,
			16'hffff, x_at15 | x_exy, x_at15 | x_exy});
		put('{ws_at, asl_zero, c_bw | c_s1 | c_wx | c_axy, 0, 0, 0, 0, 0, 16'hb000, 16'hffff,
			0, x_at15 | x_exy});
		put('{ws_at, asl_l, c_bw, 16'h0200, 0, 0, 16'hc002, 0, 16'h5800, 16'hffff, x_exy,
			x_at15 | x_exx | x_exy});
	endtask

	initial begin
		build_table();
		limit = 2 * tbl.size() + 50;
		arst_n = 1'b0;
		drive('{ws_zero, asl_zero, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0});
		repeat (10) @(posedge clk);
		#1 arst_n = 1'b1;
		foreach (tbl[i]) begin
			@(posedge clk);
			#1;
			cur_row = i;
			drive(tbl[i]);
			#6;
			verify_row(tbl[i]);
		end
		$display("checks: %0d, errors: %0d", nchk, nerr);
		if (nerr == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		@(posedge clk);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the stimulus table did not finish within %0d cycles", limit);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: rtl/acc_flags.sv
`timescale 1ns/1ps

module acc_flags (
	input  logic clk,
	input  logic arst_n,
	input  logic ac_load,
	input  logic wzi_cap,
	input  logic am1,
	input  logic apb,
	input  logic amb,
	input  logic ap1,
	input  pa_pkg::word_t w,
	input  pa_pkg::word_t a,
	input  logic carry,
	input  logic zsum_,
	output pa_pkg::word_t ac,
	output logic s_1,
	output logic zs,
	output logic wzi
);

	logic sgn_ne;
	logic sgn_sel;

	// accumulator
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ac <= '0;
		end else if (ac_load) begin
			ac <= w;
		end
	end

	// operand signs differ
	assign sgn_ne = a[0] ^ ac[0];

	// sign term picked by the operation class
	assign sgn_sel = (~a[0] & am1) | (sgn_ne & apb) | (~sgn_ne & amb) | (a[0] & ap1);

	// sign extension bit, corrected by the carry out of bit 0
	assign s_1 = sgn_sel ^ carry;

	// zero result with no extension
	assign zs = ~(s_1 | zsum_);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wzi <= 1'b0;
		end else if (wzi_cap) begin
			wzi <= zs;
		end
	end

endmodule

// File: rtl/addr_regs.sv
`timescale 1ns/1ps

module addr_regs #(
	parameter int unsigned ar_step = 4
) (
	input  logic clk,
	input  logic arst_n,
	input  logic ar_load,
	input  logic ar_inc,
	input  logic arm4,
	input  logic ic_load,
	input  logic ic_inc,
	input  logic off,
	input  logic ar_ad,
	input  logic ic_ad,
	input  logic barnb,
	input  pa_pkg::word_t w,
	input  pa_pkg::word_t kl,
	output pa_pkg::word_t ar,
	output pa_pkg::word_t ic,
	output pa_pkg::word_t dad_,
	output logic arz,
	output logic zga
);
	import pa_pkg::*;

	word_t addr;
	byte_t ar_hi;
	byte_t key_hi;

	// argument register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ar <= '0;
		end else if (ar_load) begin
			ar <= w;
		end else if (ar_inc) begin
			ar <= ar + 16'd1;
		end else if (arm4) begin
			ar <= ar - word_t'(ar_step);
		end
	end

	// instruction counter, off wins over everything
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ic <= '0;
		end else if (off) begin
			ic <= '0;
		end else if (ic_load) begin
			ic <= w;
		end else if (ic_inc) begin
			ic <= ic + 16'd1;
		end
	end

	// address bus is active low
	assign addr = ({16{ar_ad}} & ar) | ({16{ic_ad}} & ic);
	assign dad_ = ~addr;

	assign ar_hi = ar[0:7];
	assign arz = |ar_hi;

	// key lines against the address, barnb in place of bit 0
	assign key_hi = {barnb, addr[1:7]};
	assign zga = (kl[0:7] == key_hi) && (kl[8:15] == addr[8:15]);

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu (
	input  pa_pkg::word_t a,
	input  pa_pkg::word_t ac,
	input  logic saryt,
	input  logic sd,
	input  logic sb,
	input  logic scb,
	input  logic sab,
	input  logic sca,
	input  logic saa,
	input  logic p16,
	output pa_pkg::word_t f,
	output logic carry,
	output logic j$,
	output logic zsum_
);
	import pa_pkg::*;

	// one 74181-style byte slice, active high data and carries
	// s is {S3, S2, S1, S0}, m high selects logic mode
	// result is {carry out, f}
	function automatic logic [8:0] slice181(
		input byte_t x,
		input byte_t y,
		input logic [3:0] s,
		input logic m,
		input logic cin
	);
		byte_t r;
		logic c;
		logic p;
		logic g;
		c = cin;
		// bit 7 is the least significant bit of the byte
		for (int i = 7; i >= 0; i--) begin
			p = x[i] | (s[0] & y[i]) | (s[1] & ~y[i]);
			g = (s[2] & x[i] & ~y[i]) | (s[3] & x[i] & y[i]);
			// logic mode ignores the ripple carry
			r[i] = p ^ g ^ (m | c);
			c = g | (p & c);
		end
		return {c, r};
	endfunction

	logic mode_l;
	logic [8:0] lo_res;
	logic [8:0] hi_res;

	assign mode_l = ~saryt;

	// low byte, bits 8..15, carry in at bit 15
	assign lo_res = slice181(a[8:15], ac[8:15], {sd, sb, sca, saa}, mode_l, p16);
	assign j$ = lo_res[8];

	// high byte, bits 0..7, fed by the byte carry
	assign hi_res = slice181(a[0:7], ac[0:7], {sd, sb, scb, sab}, mode_l, j$);
	assign carry = hi_res[8];

	assign f = {hi_res[7:0], lo_res[7:0]};

	// low on a zero result
	assign zsum_ = |f;

endmodule

// File: rtl/at_reg.sv
`timescale 1ns/1ps

module at_reg (
	input  logic clk,
	input  logic arst_n,
	input  pa_pkg::at_mode_t mode,
	input  logic sin,
	input  pa_pkg::word_t f,
	output pa_pkg::word_t at
);
	import pa_pkg::*;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			at <= '0;
		end else begin
			case (mode)
				at_load: begin
					at <= f;
				end
				// toward bit 15, sin enters at the msb
				at_shr: begin
					at <= {sin, at[0:14]};
				end
				at_clear: begin
					at <= '0;
				end
				default: begin
					at <= at;
				end
			endcase
		end
	end

endmodule

// File: rtl/bus_a.sv
`timescale 1ns/1ps

module bus_a (
	input  pa_pkg::asel_t asel,
	input  logic aa,
	input  logic ab,
	input  pa_pkg::word_t ir,
	input  pa_pkg::word_t l,
	input  pa_pkg::word_t ar,
	input  pa_pkg::word_t ic,
	input  pa_pkg::word_t ac,
	output pa_pkg::word_t a
);
	import pa_pkg::*;

	word_t src;
	word_t irs;

	// 7-bit short argument, sign in ir[9]
	assign irs = {{10{ir[9]}}, ir[10:15]};

	always_comb begin
		case (asel)
			asl_zero: src = '0;
			asl_ir:   src = ir;
			asl_ar:   src = ar;
			asl_ic:   src = ic;
			asl_l:    src = l;
			asl_irs:  src = irs;
			asl_ac:   src = ac;
			default:  src = '1;
		endcase
	end

	// upper byte fill
	always_comb begin
		a = src;
		case ({aa, ab})
			2'b10:   a[0:7] = 8'h00;
			2'b01:   a[0:7] = 8'hff;
			// sign of the lower byte
			2'b11:   a[0:7] = {8{src[8]}};
			default: a[0:7] = src[0:7];
		endcase
	end

endmodule

// File: rtl/bus_w.sv
`timescale 1ns/1ps

module bus_w (
	input  pa_pkg::wsel_t wsel,
	input  logic bwa,
	input  logic bwb,
	input  pa_pkg::word_t ir,
	input  pa_pkg::word_t kl,
	input  pa_pkg::word_t rdt_,
	input  pa_pkg::word_t ki,
	input  pa_pkg::word_t at,
	input  pa_pkg::word_t ac,
	input  pa_pkg::word_t a,
	output pa_pkg::word_t w
);
	import pa_pkg::*;

	word_t src;

	// source select
	always_comb begin
		case (wsel)
			ws_ki:   src = ki;
			ws_ir:   src = ir;
			ws_kl:   src = kl;
			// memory data bus is active low
			ws_rdt:  src = ~rdt_;
			ws_ac:   src = ac;
			ws_at:   src = at;
			ws_a:    src = a;
			default: src = '0;
		endcase
	end

	// byte gating, a disabled byte reads as zero
	always_comb begin
		w = src;
		if (!bwa) begin
			w[0:7] = 8'h00;
		end
		if (!bwb) begin
			w[8:15] = 8'h00;
		end
	end

endmodule

// File: rtl/pa.sv
`timescale 1ns/1ps

module pa #(
	parameter int unsigned ar_step = 4
) (
	input  logic clk,
	input  logic arst_n,
	// W bus and data bus
	input  pa_pkg::word_t ir,
	input  pa_pkg::word_t bus_ki,
	input  pa_pkg::word_t rdt_,
	input  logic w_dt,
	input  logic mwa, mwb, mwc,
	input  logic bwa, bwb,
	output pa_pkg::word_t ddt_,
	output pa_pkg::word_t w,
	// ALU
	input  logic saryt, sab, scb, saa, sca, sb, sd, p16,
	output logic s0, carry, j$, exx,
	// AT
	input  logic wx, eat0, axy,
	output logic at15, exy,
	// AC and flags
	input  logic w_ac, strob1, strob2, as2,
	input  logic am1, apb, amb, ap1,
	output logic s_1, wzi, zs,
	// AR and IC
	input  logic w_ar, arp1, arm4,
	input  logic w_ic, icp1, off,
	output logic arz,
	// A bus
	input  logic baa, bab, bac, aa, ab,
	input  pa_pkg::word_t l,
	// address bus and key comparison
	input  logic barnb, ar_ad, ic_ad,
	input  pa_pkg::word_t kl,
	output pa_pkg::word_t dad_,
	output logic zga
);
	import pa_pkg::*;

	word_t a;
	word_t f;
	word_t at;
	word_t ac;
	word_t ar;
	word_t ic;
	logic zsum_;
	wsel_t wsel;
	asel_t asel;
	at_mode_t at_mode;
	logic stroba;
	logic strobb;
	logic strob_ab;

	// strobe phases
	assign stroba = strob1 & ~as2;
	assign strobb = strob2 & as2;
	assign strob_ab = stroba | strobb;

	assign wsel = wsel_t'({mwc, mwb, mwa});
	assign asel = asel_t'({bac, bab, baa});

	// load with as2 high, shift with wx in the other phase
	always_comb begin
		if (strob1 && as2) begin
			at_mode = at_load;
		end else if (strob1 && wx) begin
			at_mode = at_shr;
		end else begin
			at_mode = at_hold;
		end
	end

	bus_w u_bus_w (
		.wsel, .bwa, .bwb, .ir, .kl, .rdt_,
		.ki(bus_ki), .at, .ac, .a, .w
	);

	bus_a u_bus_a (
		.asel, .aa, .ab, .ir, .l, .ar, .ic, .ac, .a
	);

	alu u_alu (
		.a, .ac, .saryt, .sd, .sb, .scb, .sab, .sca, .saa, .p16,
		.f, .carry, .j$, .zsum_
	);

	at_reg u_at_reg (
		.clk, .arst_n, .mode(at_mode), .sin(eat0), .f, .at
	);

	acc_flags u_acc_flags (
		.clk, .arst_n,
		.ac_load(w_ac & strob_ab),
		.wzi_cap(strob1 & as2),
		.am1, .apb, .amb, .ap1, .w, .a, .carry, .zsum_,
		.ac, .s_1, .zs, .wzi
	);

	addr_regs #(
		.ar_step(ar_step)
	) u_addr_regs (
		.clk, .arst_n,
		.ar_load(w_ar & strob_ab),
		.ar_inc(arp1 & stroba),
		.arm4,
		.ic_load(w_ic & strob_ab),
		.ic_inc(icp1 & strob1),
		.off, .ar_ad, .ic_ad, .barnb, .w, .kl,
		.ar, .ic, .dad_, .arz, .zga
	);

	// data bus is active low
	assign ddt_ = ~(w & {16{w_dt}});

	assign s0 = f[0];
	assign exx = ir[6] ? a[15] : a[0];
	assign at15 = at[15];
	assign exy = axy ? at15 : a[0];

endmodule

// File: rtl/pa_pkg.sv
package pa_pkg;

	// bit 0 is the most significant bit everywhere
	typedef logic [0:15] word_t;
	typedef logic [0:7] byte_t;

	// W bus source, coded as {mwc, mwb, mwa}
	typedef enum logic [2:0] {
		ws_ki   = 3'd0,
		ws_ir   = 3'd1,
		ws_kl   = 3'd2,
		ws_rdt  = 3'd3,
		ws_ac   = 3'd4,
		ws_at   = 3'd5,
		ws_a    = 3'd6,
		ws_zero = 3'd7
	} wsel_t;

	// A bus source, coded as {bac, bab, baa}
	typedef enum logic [2:0] {
		asl_zero = 3'd0,
		asl_ir   = 3'd1,
		asl_ar   = 3'd2,
		asl_ic   = 3'd3,
		asl_l    = 3'd4,
		// short argument from the instruction word
		asl_irs  = 3'd5,
		asl_ac   = 3'd6,
		asl_ones = 3'd7
	} asel_t;

	// AT register operation
	typedef enum logic [1:0] {
		at_hold  = 2'd0,
		at_shr   = 2'd1,
		at_load  = 2'd2,
		at_clear = 2'd3
	} at_mode_t;

endpackage

// File: verilog.f
rtl/pa_pkg.sv
rtl/bus_w.sv
rtl/bus_a.sv
rtl/alu.sv
rtl/at_reg.sv
rtl/acc_flags.sv
rtl/addr_regs.sv
rtl/pa.sv
bench/pa_props.sv
bench/pa_tb.sv
